// File: src/lc4_pkg.sv
/*
 * Shared LC4 core definitions
 * Word, register-select and condition-code widths, default reset PC,
 * opcode and arithmetic subop codes, operand bypass select codes,
 * and the packed union that gives the views of one instruction word
 */
package lc4_pkg;

  parameter int WORD_W    = 16;
  parameter int REG_SEL_W = 3;
  parameter int NZP_W     = 3;

  parameter logic [WORD_W-1:0] RESET_PC = 16'h8200;

  // Primary opcodes, insn[15:12]
  parameter logic [3:0] OP_BR    = 4'b0000;
  parameter logic [3:0] OP_ARITH = 4'b0001;
  parameter logic [3:0] OP_AND   = 4'b0101;
  parameter logic [3:0] OP_LDR   = 4'b0110;
  parameter logic [3:0] OP_STR   = 4'b0111;
  parameter logic [3:0] OP_CONST = 4'b1001;

  // Register-form arithmetic subops, insn[5:3]
  parameter logic [2:0] SUB_ADD = 3'b000;
  parameter logic [2:0] SUB_SUB = 3'b010;

  // Execute operand source
  parameter logic [1:0] FWD_NONE = 2'b00;
  parameter logic [1:0] FWD_MEM  = 2'b01;
  parameter logic [1:0] FWD_WB   = 2'b10;

  typedef struct packed {
    logic [3:0]           opcode;
    logic [REG_SEL_W-1:0] rd;
    logic [REG_SEL_W-1:0] rs;
    logic [2:0]           subop;
    logic [REG_SEL_W-1:0] rt;
  } insn_rr_t;

  typedef struct packed {
    logic [3:0]           opcode;
    logic [REG_SEL_W-1:0] rd;
    logic [REG_SEL_W-1:0] rs;
    logic                 flag;
    logic [4:0]           imm5;
  } insn_ri_t;

  // STR keeps its data register in the rd slot
  typedef struct packed {
    logic [3:0]           opcode;
    logic [REG_SEL_W-1:0] rd;
    logic [REG_SEL_W-1:0] rs;
    logic [5:0]           imm6;
  } insn_mem_t;

  // CONST reuses the nzp slot as its destination
  typedef struct packed {
    logic [3:0]       opcode;
    logic [NZP_W-1:0] nzp;
    logic [8:0]       imm9;
  } insn_br_t;

  typedef union packed {
    insn_rr_t  rr;
    insn_ri_t  ri;
    insn_mem_t mem;
    insn_br_t  br;
  } lc4_insn_u;

endpackage

// File: src/lc4_decoder.sv
/*
 * LC4 instruction decoder
 * Register selects and read enables, destination, write enables,
 * load/store/branch flags and the sign-extended immediate
 */
`timescale 1ns/1ps

module lc4_decoder (
  input  lc4_pkg::lc4_insn_u             i_insn,
  output logic [lc4_pkg::REG_SEL_W-1:0] o_rs_sel,
  output logic [lc4_pkg::REG_SEL_W-1:0] o_rt_sel,
  output logic                          o_rs_re,
  output logic                          o_rt_re,
  output logic [lc4_pkg::REG_SEL_W-1:0] o_rd_sel,
  output logic                          o_rd_we,
  output logic                          o_nzp_we,
  output logic                          o_is_load,
  output logic                          o_is_store,
  output logic                          o_is_branch,
  output logic [lc4_pkg::WORD_W-1:0]    o_imm
);
  import lc4_pkg::*;

  always_comb begin
    o_rs_sel    = i_insn.rr.rs;
    o_rt_sel    = i_insn.rr.rt;
    o_rd_sel    = i_insn.rr.rd;
    o_rs_re     = 1'b0;
    o_rt_re     = 1'b0;
    o_rd_we     = 1'b0;
    o_nzp_we    = 1'b0;
    o_is_load   = 1'b0;
    o_is_store  = 1'b0;
    o_is_branch = 1'b0;
    o_imm       = '0;
    case (i_insn.rr.opcode)
      OP_ARITH: begin
        // Bit 5 picks the immediate form, which has no rt
        o_rs_re  = 1'b1;
        o_rt_re  = ~i_insn.ri.flag;
        o_rd_we  = 1'b1;
        o_nzp_we = 1'b1;
        o_imm    = {{(WORD_W-5){i_insn.ri.imm5[4]}}, i_insn.ri.imm5};
      end
      OP_AND: begin
        o_rs_re  = 1'b1;
        o_rt_re  = 1'b1;
        o_rd_we  = 1'b1;
        o_nzp_we = 1'b1;
      end
      OP_LDR: begin
        o_rs_re   = 1'b1;
        o_rd_we   = 1'b1;
        o_nzp_we  = 1'b1;
        o_is_load = 1'b1;
        o_imm     = {{(WORD_W-6){i_insn.mem.imm6[5]}}, i_insn.mem.imm6};
      end
      OP_STR: begin
        // Store data register sits where a load has its destination
        o_rt_sel   = i_insn.mem.rd;
        o_rs_re    = 1'b1;
        o_rt_re    = 1'b1;
        o_is_store = 1'b1;
        o_imm      = {{(WORD_W-6){i_insn.mem.imm6[5]}}, i_insn.mem.imm6};
      end
      OP_CONST: begin
        o_rd_we  = 1'b1;
        o_nzp_we = 1'b1;
        o_imm    = {{(WORD_W-9){i_insn.br.imm9[8]}}, i_insn.br.imm9};
      end
      OP_BR: begin
        o_is_branch = 1'b1;
        o_imm       = {{(WORD_W-9){i_insn.br.imm9[8]}}, i_insn.br.imm9};
      end
      default: begin
        o_rd_we = 1'b0;
      end
    endcase
  end

endmodule

// File: src/lc4_regfile.sv
/*
 * Eight-entry LC4 register file
 * Two read ports, one write port, reads see a same-cycle write
 */
`timescale 1ns/1ps

module lc4_regfile (
  input  logic                          gwe,
  input  logic                          i_rst,
  input  logic [lc4_pkg::REG_SEL_W-1:0] i_rs_sel,
  input  logic [lc4_pkg::REG_SEL_W-1:0] i_rt_sel,
  input  logic [lc4_pkg::REG_SEL_W-1:0] i_rd_sel,
  input  logic                          i_rd_we,
  input  logic [lc4_pkg::WORD_W-1:0]    i_wdata,
  output logic [lc4_pkg::WORD_W-1:0]    o_rs_data,
  output logic [lc4_pkg::WORD_W-1:0]    o_rt_data
);
  import lc4_pkg::*;

  logic [WORD_W-1:0] regs [2**REG_SEL_W];

  always_ff @(posedge gwe) begin
    if (i_rst) begin
      for (int i = 0; i < 2**REG_SEL_W; i++) begin
        regs[i] <= '0;
      end
    end else if (i_rd_we) begin
      regs[i_rd_sel] <= i_wdata;
    end
  end

  // Writeback value wins over the stored one (WD bypass)
  assign o_rs_data = (i_rd_we && i_rd_sel == i_rs_sel) ? i_wdata : regs[i_rs_sel];
  assign o_rt_data = (i_rd_we && i_rd_sel == i_rt_sel) ? i_wdata : regs[i_rt_sel];

endmodule

// File: src/lc4_alu.sv
/*
 * LC4 execute-stage ALU
 * ADD, SUB, AND, ADD immediate, CONST and load/store address
 */
`timescale 1ns/1ps

module lc4_alu (
  input  lc4_pkg::lc4_insn_u          i_insn,
  input  logic [lc4_pkg::WORD_W-1:0] i_rs_data,
  input  logic [lc4_pkg::WORD_W-1:0] i_rt_data,
  input  logic [lc4_pkg::WORD_W-1:0] i_imm,
  output logic [lc4_pkg::WORD_W-1:0] o_result
);
  import lc4_pkg::*;

  always_comb begin
    o_result = '0;
    case (i_insn.rr.opcode)
      OP_ARITH: begin
        if (i_insn.ri.flag) begin
          o_result = i_rs_data + i_imm;
        end else begin
          case (i_insn.rr.subop)
            SUB_ADD: o_result = i_rs_data + i_rt_data;
            SUB_SUB: o_result = i_rs_data - i_rt_data;
            default: o_result = '0;
          endcase
        end
      end
      OP_AND: o_result = i_rs_data & i_rt_data;
      // Base plus imm6 for both memory ops
      OP_LDR,
      OP_STR: o_result = i_rs_data + i_imm;
      OP_CONST: o_result = i_imm;
      default: o_result = '0;
    endcase
  end

endmodule

// File: src/lc4_hazard_unit.sv
/*
 * LC4 hazard unit
 * MX/WX operand bypass selects, WM store-data select
 * and load-use stall detection
 */
`timescale 1ns/1ps

module lc4_hazard_unit (
  input  logic [lc4_pkg::REG_SEL_W-1:0] i_d_rs_sel,
  input  logic [lc4_pkg::REG_SEL_W-1:0] i_d_rt_sel,
  input  logic                          i_d_rs_re,
  input  logic                          i_d_rt_re,
  input  logic                          i_d_is_store,
  input  logic [lc4_pkg::REG_SEL_W-1:0] i_x_rs_sel,
  input  logic [lc4_pkg::REG_SEL_W-1:0] i_x_rt_sel,
  input  logic [lc4_pkg::REG_SEL_W-1:0] i_x_rd_sel,
  input  logic                          i_x_rd_we,
  input  logic                          i_x_is_load,
  input  logic [lc4_pkg::REG_SEL_W-1:0] i_m_rd_sel,
  input  logic                          i_m_rd_we,
  input  logic [lc4_pkg::REG_SEL_W-1:0] i_m_rt_sel,
  input  logic                          i_m_is_store,
  input  logic [lc4_pkg::REG_SEL_W-1:0] i_w_rd_sel,
  input  logic                          i_w_rd_we,
  output logic [1:0]                    o_rs_fwd,
  output logic [1:0]                    o_rt_fwd,
  output logic                          o_store_wm_fwd,
  output logic                          o_load_stall
);
  import lc4_pkg::*;

  logic rs_use;
  logic rt_use;

  // Memory stage holds the younger result, so it is checked first
  always_comb begin
    o_rs_fwd = FWD_NONE;
    o_rt_fwd = FWD_NONE;
    if (i_m_rd_we && i_m_rd_sel == i_x_rs_sel) begin
      o_rs_fwd = FWD_MEM;
    end else if (i_w_rd_we && i_w_rd_sel == i_x_rs_sel) begin
      o_rs_fwd = FWD_WB;
    end
    if (i_m_rd_we && i_m_rd_sel == i_x_rt_sel) begin
      o_rt_fwd = FWD_MEM;
    end else if (i_w_rd_we && i_w_rd_sel == i_x_rt_sel) begin
      o_rt_fwd = FWD_WB;
    end
  end

  // Store data from the instruction just ahead, loads included
  assign o_store_wm_fwd = i_m_is_store && i_w_rd_we && (i_w_rd_sel == i_m_rt_sel);

  // Store data of a dependent STR is covered by the WM path
  assign rs_use = i_d_rs_re && (i_d_rs_sel == i_x_rd_sel);
  assign rt_use = i_d_rt_re && !i_d_is_store && (i_d_rt_sel == i_x_rd_sel);

  assign o_load_stall = i_x_is_load && i_x_rd_we && (rs_use || rt_use);

endmodule

// File: src/lc4_branch_unit.sv
/*
 * LC4 branch unit
 * PC and NZP registers, bypassed NZP, BR resolution in execute
 * and next-PC selection
 */
`timescale 1ns/1ps

module lc4_branch_unit #(
  parameter logic [lc4_pkg::WORD_W-1:0] RESET_PC = lc4_pkg::RESET_PC
) (
  input  logic                       gwe,
  input  logic                       i_rst,
  input  logic                       i_hold,
  input  lc4_pkg::lc4_insn_u         i_x_insn,
  input  logic                       i_x_is_branch,
  input  logic                       i_m_nzp_we,
  input  logic [lc4_pkg::WORD_W-1:0] i_m_result,
  input  logic                       i_w_nzp_we,
  input  logic [lc4_pkg::WORD_W-1:0] i_w_data,
  output logic [lc4_pkg::WORD_W-1:0] o_pc,
  output logic                       o_flush
);
  import lc4_pkg::*;

  logic [NZP_W-1:0]  nzp_q;
  logic [NZP_W-1:0]  nzp_byp;
  logic [WORD_W-1:0] imm9_ext;
  logic [WORD_W-1:0] target;

  function automatic logic [NZP_W-1:0] nzp_of(input logic [WORD_W-1:0] value);
    if (value[WORD_W-1]) begin
      return 3'b100;
    end else if (value == '0) begin
      return 3'b010;
    end
    return 3'b001;
  endfunction

  // Youngest setter first
  always_comb begin
    if (i_m_nzp_we) begin
      nzp_byp = nzp_of(i_m_result);
    end else if (i_w_nzp_we) begin
      nzp_byp = nzp_of(i_w_data);
    end else begin
      nzp_byp = nzp_q;
    end
  end

  assign o_flush  = i_x_is_branch && |(i_x_insn.br.nzp & nzp_byp);
  assign imm9_ext = {{(WORD_W-9){i_x_insn.br.imm9[8]}}, i_x_insn.br.imm9};

  // Fetch is two ahead of execute, so branch PC + 1 is o_pc - 1
  assign target = o_pc - 1'b1 + imm9_ext;

  always_ff @(posedge gwe) begin
    if (i_rst) begin
      o_pc  <= RESET_PC;
      nzp_q <= 3'b010;
    end else begin
      if (o_flush) begin
        o_pc <= target;
      end else if (!i_hold) begin
        o_pc <= o_pc + 1'b1;
      end
      if (i_w_nzp_we) begin
        nzp_q <= nzp_of(i_w_data);
      end
    end
  end

endmodule

// File: src/lc4_processor.sv
/*
 * LC4 five-stage pipelined core
 * Decode, execute, memory and writeback registers, operand bypass muxes,
 * load-use bubble and branch flush, memory and commit ports
 */
`timescale 1ns/1ps

module lc4_processor #(
  parameter logic [lc4_pkg::WORD_W-1:0] RESET_PC = lc4_pkg::RESET_PC
) (
  input  logic                          gwe,
  input  logic                          i_rst,
  output logic [lc4_pkg::WORD_W-1:0]    o_imem_addr,
  input  logic [lc4_pkg::WORD_W-1:0]    i_imem_data,
  output logic [lc4_pkg::WORD_W-1:0]    o_dmem_addr,
  output logic                          o_dmem_we,
  output logic [lc4_pkg::WORD_W-1:0]    o_dmem_wdata,
  input  logic [lc4_pkg::WORD_W-1:0]    i_dmem_rdata,
  output logic                          o_wb_we,
  output logic [lc4_pkg::REG_SEL_W-1:0] o_wb_sel,
  output logic [lc4_pkg::WORD_W-1:0]    o_wb_data,
  output logic [lc4_pkg::WORD_W-1:0]    o_wb_pc
);
  import lc4_pkg::*;

  logic [WORD_W-1:0]    pc;
  logic                 flush;
  logic                 load_stall;
  logic [1:0]           rs_fwd;
  logic [1:0]           rt_fwd;
  logic                 store_wm_fwd;

  // Decode stage
  lc4_insn_u            d_insn;
  logic [WORD_W-1:0]    d_pc;
  logic [REG_SEL_W-1:0] d_rs_sel, d_rt_sel, d_rd_sel;
  logic                 d_rs_re, d_rt_re;
  logic                 d_rd_we, d_nzp_we, d_is_load, d_is_store, d_is_branch;
  logic [WORD_W-1:0]    d_imm, d_rs_data, d_rt_data;

  // Execute stage
  lc4_insn_u            x_insn;
  logic [WORD_W-1:0]    x_pc;
  logic [REG_SEL_W-1:0] x_rs_sel, x_rt_sel, x_rd_sel;
  logic                 x_rd_we, x_nzp_we, x_is_load, x_is_store, x_is_branch;
  logic [WORD_W-1:0]    x_imm, x_rs_data, x_rt_data;
  logic [WORD_W-1:0]    x_rs_val, x_rt_val, x_result;

  // Memory stage
  logic [WORD_W-1:0]    m_pc, m_result, m_store_data, m_value;
  logic [REG_SEL_W-1:0] m_rt_sel, m_rd_sel;
  logic                 m_rd_we, m_nzp_we, m_is_load, m_is_store;

  // Writeback stage
  logic [WORD_W-1:0]    w_pc, w_result, w_load_data, w_data;
  logic [REG_SEL_W-1:0] w_rd_sel;
  logic                 w_rd_we, w_nzp_we, w_is_load;

  function automatic logic [WORD_W-1:0] bypass(
    input logic [1:0]        sel,
    input logic [WORD_W-1:0] m_val,
    input logic [WORD_W-1:0] w_val,
    input logic [WORD_W-1:0] reg_val
  );
    case (sel)
      FWD_MEM: return m_val;
      FWD_WB:  return w_val;
      default: return reg_val;
    endcase
  endfunction

  assign o_imem_addr = pc;

  // Fetch to decode, held on a load-use stall
  always_ff @(posedge gwe) begin
    if (i_rst || flush) begin
      d_insn <= '0;
    end else if (!load_stall) begin
      d_insn <= i_imem_data;
    end
  end

  always_ff @(posedge gwe) begin
    if (!load_stall) begin
      d_pc <= pc;
    end
  end

  lc4_decoder u_decoder (
    .i_insn      (d_insn),
    .o_rs_sel    (d_rs_sel),
    .o_rt_sel    (d_rt_sel),
    .o_rs_re     (d_rs_re),
    .o_rt_re     (d_rt_re),
    .o_rd_sel    (d_rd_sel),
    .o_rd_we     (d_rd_we),
    .o_nzp_we    (d_nzp_we),
    .o_is_load   (d_is_load),
    .o_is_store  (d_is_store),
    .o_is_branch (d_is_branch),
    .o_imm       (d_imm)
  );

  lc4_regfile u_regfile (
    .gwe       (gwe),
    .i_rst     (i_rst),
    .i_rs_sel  (d_rs_sel),
    .i_rt_sel  (d_rt_sel),
    .i_rd_sel  (w_rd_sel),
    .i_rd_we   (w_rd_we),
    .i_wdata   (w_data),
    .o_rs_data (d_rs_data),
    .o_rt_data (d_rt_data)
  );

  // Bubble into execute on stall or flush
  always_ff @(posedge gwe) begin
    if (i_rst || flush || load_stall) begin
      x_rd_we     <= 1'b0;
      x_nzp_we    <= 1'b0;
      x_is_load   <= 1'b0;
      x_is_store  <= 1'b0;
      x_is_branch <= 1'b0;
    end else begin
      x_rd_we     <= d_rd_we;
      x_nzp_we    <= d_nzp_we;
      x_is_load   <= d_is_load;
      x_is_store  <= d_is_store;
      x_is_branch <= d_is_branch;
    end
  end

  always_ff @(posedge gwe) begin
    x_insn    <= d_insn;
    x_pc      <= d_pc;
    x_rs_sel  <= d_rs_sel;
    x_rt_sel  <= d_rt_sel;
    x_rd_sel  <= d_rd_sel;
    x_imm     <= d_imm;
    x_rs_data <= d_rs_data;
    x_rt_data <= d_rt_data;
  end

  lc4_hazard_unit u_hazard (
    .i_d_rs_sel     (d_rs_sel),
    .i_d_rt_sel     (d_rt_sel),
    .i_d_rs_re      (d_rs_re),
    .i_d_rt_re      (d_rt_re),
    .i_d_is_store   (d_is_store),
    .i_x_rs_sel     (x_rs_sel),
    .i_x_rt_sel     (x_rt_sel),
    .i_x_rd_sel     (x_rd_sel),
    .i_x_rd_we      (x_rd_we),
    .i_x_is_load    (x_is_load),
    .i_m_rd_sel     (m_rd_sel),
    .i_m_rd_we      (m_rd_we),
    .i_m_rt_sel     (m_rt_sel),
    .i_m_is_store   (m_is_store),
    .i_w_rd_sel     (w_rd_sel),
    .i_w_rd_we      (w_rd_we),
    .o_rs_fwd       (rs_fwd),
    .o_rt_fwd       (rt_fwd),
    .o_store_wm_fwd (store_wm_fwd),
    .o_load_stall   (load_stall)
  );

  // MX and WX paths
  assign x_rs_val = bypass(rs_fwd, m_result, w_data, x_rs_data);
  assign x_rt_val = bypass(rt_fwd, m_result, w_data, x_rt_data);

  lc4_alu u_alu (
    .i_insn    (x_insn),
    .i_rs_data (x_rs_val),
    .i_rt_data (x_rt_val),
    .i_imm     (x_imm),
    .o_result  (x_result)
  );

  // A load in memory already has its data, so BR sees the loaded value
  assign m_value = m_is_load ? i_dmem_rdata : m_result;

  lc4_branch_unit #(
    .RESET_PC (RESET_PC)
  ) u_branch (
    .gwe           (gwe),
    .i_rst         (i_rst),
    .i_hold        (load_stall),
    .i_x_insn      (x_insn),
    .i_x_is_branch (x_is_branch),
    .i_m_nzp_we    (m_nzp_we),
    .i_m_result    (m_value),
    .i_w_nzp_we    (w_nzp_we),
    .i_w_data      (w_data),
    .o_pc          (pc),
    .o_flush       (flush)
  );

  always_ff @(posedge gwe) begin
    if (i_rst) begin
      m_rd_we    <= 1'b0;
      m_nzp_we   <= 1'b0;
      m_is_load  <= 1'b0;
      m_is_store <= 1'b0;
      w_rd_we    <= 1'b0;
      w_nzp_we   <= 1'b0;
      w_is_load  <= 1'b0;
    end else begin
      m_rd_we    <= x_rd_we;
      m_nzp_we   <= x_nzp_we;
      m_is_load  <= x_is_load;
      m_is_store <= x_is_store;
      w_rd_we    <= m_rd_we;
      w_nzp_we   <= m_nzp_we;
      w_is_load  <= m_is_load;
    end
  end

  always_ff @(posedge gwe) begin
    m_pc         <= x_pc;
    m_result     <= x_result;
    m_store_data <= x_rt_val;
    m_rt_sel     <= x_rt_sel;
    m_rd_sel     <= x_rd_sel;
    w_pc         <= m_pc;
    w_result     <= m_result;
    w_load_data  <= i_dmem_rdata;
    w_rd_sel     <= m_rd_sel;
  end

  assign o_dmem_addr  = m_result;
  assign o_dmem_we    = m_is_store;
  // WM path for a value still in writeback
  assign o_dmem_wdata = store_wm_fwd ? w_data : m_store_data;

  assign w_data = w_is_load ? w_load_data : w_result;

  assign o_wb_we   = w_rd_we;
  assign o_wb_sel  = w_rd_sel;
  assign o_wb_data = w_data;
  assign o_wb_pc   = w_pc;

endmodule

// File: test/lc4_clock_gen.sv
/*
 * Testbench clock and reset source
 * Free-running gwe clock, reset held for a fixed number of cycles
 */
`timescale 1ns/1ps

module lc4_clock_gen #(
  parameter int PERIOD_NS      = 10,
  parameter int RESET_CYCLES   = 8,
  parameter int DRIVE_DELAY_NS = 1
) (
  output logic gwe,
  output logic o_rst
);

  initial begin
    gwe = 1'b0;
    forever begin
      #(PERIOD_NS / 2) gwe = ~gwe;
    end
  end

  // Reset drops just after a rising edge
  initial begin
    o_rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge gwe);
    #(DRIVE_DELAY_NS) o_rst = 1'b0;
  end

endmodule

// File: test/lc4_properties.sv
/*
 * Bound checks on the LC4 core
 * Quiet write enables in reset, known store address,
 * no repeated PC on consecutive commits
 */
`timescale 1ns/1ps

module lc4_properties (
  input logic                       gwe,
  input logic                       i_rst,
  input logic                       i_dmem_we,
  input logic [lc4_pkg::WORD_W-1:0] i_dmem_addr,
  input logic                       i_wb_we,
  input logic [lc4_pkg::WORD_W-1:0] i_wb_pc
);
  import lc4_pkg::*;

  int unsigned       assert_fails = 0;
  logic              have_prev;
  logic [WORD_W-1:0] prev_pc;

  // PC of the most recent commit
  always_ff @(posedge gwe) begin
    if (i_rst) begin
      have_prev <= 1'b0;
      prev_pc   <= '0;
    end else if (i_wb_we) begin
      have_prev <= 1'b1;
      prev_pc   <= i_wb_pc;
    end
  end

  a_quiet_in_reset: assert property (@(posedge gwe) i_rst |=> (!i_dmem_we && !i_wb_we))
    else begin
      assert_fails++;
      $error("Write enable high while in reset");
    end

  a_store_addr_known: assert property (@(posedge gwe) disable iff (i_rst)
    i_dmem_we |-> !$isunknown(i_dmem_addr))
    else begin
      assert_fails++;
      $error("Data memory write with unknown address");
    end

  a_commit_pc_moves: assert property (@(posedge gwe) disable iff (i_rst)
    (i_wb_we && have_prev) |-> (i_wb_pc != prev_pc))
    else begin
      assert_fails++;
      $error("Commit repeats the previous commit PC %h", prev_pc);
    end

endmodule

bind lc4_processor lc4_properties u_props (
  .gwe         (gwe),
  .i_rst       (i_rst),
  .i_dmem_we   (o_dmem_we),
  .i_dmem_addr (o_dmem_addr),
  .i_wb_we     (o_wb_we),
  .i_wb_pc     (o_wb_pc)
);

// File: test/lc4_tb.sv
/*
 * LC4 core testbench
 * Program and expectation table, instruction and data memory models,
 * commit and store checks against the table, watchdog
 */
`timescale 1ns/1ps

module lc4_tb;
  import lc4_pkg::*;

  localparam logic [15:0] START_PC    = 16'h8200;
  localparam int          MAX_ENTRIES = 32;
  localparam int          CLK_PERIOD  = 10;
  localparam logic [31:0] SEED        = 32'h805d59d4;

  // What an entry leaves behind
  localparam int KIND_NONE  = 0;
  localparam int KIND_WB    = 1;
  localparam int KIND_STORE = 2;

  logic                 gwe;
  logic                 rst;
  logic [WORD_W-1:0]    imem_addr;
  logic [WORD_W-1:0]    imem_data;
  logic [WORD_W-1:0]    dmem_addr;
  logic                 dmem_we;
  logic [WORD_W-1:0]    dmem_wdata;
  logic [WORD_W-1:0]    dmem_rdata;
  logic                 wb_we;
  logic [REG_SEL_W-1:0] wb_sel;
  logic [WORD_W-1:0]    wb_data;
  logic [WORD_W-1:0]    wb_pc;

  logic [WORD_W-1:0]    imem [0:65535];
  logic [WORD_W-1:0]    dmem [0:65535];

  logic [WORD_W-1:0]    tab_insn [MAX_ENTRIES];
  int                   tab_kind [MAX_ENTRIES];
  logic [REG_SEL_W-1:0] tab_sel  [MAX_ENTRIES];
  logic [WORD_W-1:0]    tab_addr [MAX_ENTRIES];
  logic [WORD_W-1:0]    tab_data [MAX_ENTRIES];

  int   n_entries = 0;
  int   n_wb = 0;
  int   n_st = 0;
  int   wb_idx = 0;
  int   st_idx = 0;
  int   commits_seen = 0;
  int   stores_seen = 0;
  int   mismatches = 0;
  int   other_errors = 0;
  logic table_ready = 1'b0;

  lc4_clock_gen #(
    .PERIOD_NS    (CLK_PERIOD),
    .RESET_CYCLES (8)
  ) u_clock (
    .gwe   (gwe),
    .o_rst (rst)
  );

  lc4_processor #(
    .RESET_PC (START_PC)
  ) dut_i (
    .gwe          (gwe),
    .i_rst        (rst),
    .o_imem_addr  (imem_addr),
    .i_imem_data  (imem_data),
    .o_dmem_addr  (dmem_addr),
    .o_dmem_we    (dmem_we),
    .o_dmem_wdata (dmem_wdata),
    .i_dmem_rdata (dmem_rdata),
    .o_wb_we      (wb_we),
    .o_wb_sel     (wb_sel),
    .o_wb_data    (wb_data),
    .o_wb_pc      (wb_pc)
  );

  // Single-cycle memories with combinational read
  assign imem_data  = imem[imem_addr];
  assign dmem_rdata = dmem[dmem_addr];

  always @(posedge gwe) begin
    if (dmem_we === 1'b1) begin
      dmem[dmem_addr] <= dmem_wdata;
    end
  end

  task automatic add_entry(input logic [15:0] insn, input int kind,
                           input logic [2:0] sel, input logic [15:0] addr,
                           input logic [15:0] data);
    tab_insn[n_entries] = insn;
    tab_kind[n_entries] = kind;
    tab_sel[n_entries]  = sel;
    tab_addr[n_entries] = addr;
    tab_data[n_entries] = data;
    if (kind == KIND_WB) begin
      n_wb++;
    end else if (kind == KIND_STORE) begin
      n_st++;
    end
    n_entries++;
  endtask

  task automatic expect_commit(input logic [15:0] insn, input logic [2:0] sel,
                               input logic [15:0] data);
    add_entry(insn, KIND_WB, sel, 16'h0000, data);
  endtask

  task automatic expect_store(input logic [15:0] insn, input logic [15:0] addr,
                              input logic [15:0] data);
    add_entry(insn, KIND_STORE, 3'd0, addr, data);
  endtask

  task automatic expect_nothing(input logic [15:0] insn);
    add_entry(insn, KIND_NONE, 3'd0, 16'h0000, 16'h0000);
  endtask

  // Expected values follow plain sequential execution
  task automatic build_program();
    logic [15:0] m43;
    logic [15:0] m45;
    m43 = dmem[16'h0043];
    m45 = dmem[16'h0045];
    expect_commit(16'h9205, 3'd1, 16'h0005);       // R1 = 5
    expect_commit(16'h95FD, 3'd2, 16'hFFFD);       // R2 = -3
    expect_commit(16'h1642, 3'd3, 16'h0002);       // R3 = R1 + R2 (MX and WX)
    expect_commit(16'h18D1, 3'd4, 16'hFFFD);       // R4 = R3 - R1 (WD on R1)
    expect_commit(16'h1B2F, 3'd5, 16'h000C);       // R5 = R4 + 15
    expect_commit(16'h5F44, 3'd7, 16'h000C);       // R7 = R5 & R4
    expect_commit(16'h1307, 3'd1, 16'h0009);       // R1 = R4 + R7
    expect_commit(16'h9C40, 3'd6, 16'h0040);       // R6 = 0x40 as load base
    expect_commit(16'h6583, 3'd2, m43);            // R2 = M[R6 + 3]
    expect_commit(16'h1681, 3'd3, m43 + 16'h0009); // Load-use stall
    expect_commit(16'h6985, 3'd4, m45);            // R4 = M[R6 + 5]
    expect_store(16'h798A, 16'h004A, m45);         // M[R6 + 10] = R4 via WM
    expect_commit(16'h6B8A, 3'd5, m45);            // Reads back the stored word
    expect_commit(16'h1FF4, 3'd7, 16'h0000);       // R7 = R7 - 12 sets Z
    expect_nothing(16'h0402);                      // BRz +2 taken
    expect_nothing(16'h9264);                      // Flushed
    expect_nothing(16'h9465);                      // Flushed
    expect_commit(16'h1241, 3'd1, 16'h0012);       // Branch target
    expect_nothing(16'h0805);                      // BRn not taken
    expect_nothing(16'h0000);                      // NOP
    expect_commit(16'h1455, 3'd2, 16'h0012 - m45);
    expect_commit(16'h16A1, 3'd3, 16'h0013 - m45);
  endtask

  function automatic int next_of_kind(input int start, input int kind);
    for (int i = start; i < n_entries; i++) begin
      if (tab_kind[i] == kind) begin
        return i;
      end
    end
    return n_entries;
  endfunction

  task automatic check_commit();
    int          idx;
    logic [15:0] exp_pc;
    idx = next_of_kind(wb_idx, KIND_WB);
    if (idx >= n_entries) begin
      other_errors++;
      $display("Unexpected register commit at %0t ns from pc %h", $time, wb_pc);
    end else begin
      exp_pc = START_PC + 16'(idx);
      commits_seen++;
      if (wb_pc !== exp_pc) begin
        mismatches++;
        $display("FAILED at %0t ns: commit pc %h, expected %h", $time, wb_pc, exp_pc);
      end
      if (wb_sel !== tab_sel[idx]) begin
        mismatches++;
        $display("FAILED at %0t ns: pc %h writes r%0d, expected r%0d",
                 $time, exp_pc, wb_sel, tab_sel[idx]);
      end
      if (wb_data !== tab_data[idx]) begin
        mismatches++;
        $display("FAILED at %0t ns: pc %h data %h, expected %h",
                 $time, exp_pc, wb_data, tab_data[idx]);
      end
      wb_idx = idx + 1;
    end
  endtask

  task automatic check_store();
    int idx;
    idx = next_of_kind(st_idx, KIND_STORE);
    if (idx >= n_entries) begin
      other_errors++;
      $display("Unexpected data memory write at %0t ns to %h", $time, dmem_addr);
    end else begin
      stores_seen++;
      if (dmem_addr !== tab_addr[idx] || dmem_wdata !== tab_data[idx]) begin
        mismatches++;
        $display("FAILED at %0t ns: store %h to %h, expected %h to %h",
                 $time, dmem_wdata, dmem_addr, tab_data[idx], tab_addr[idx]);
      end
      st_idx = idx + 1;
    end
  endtask

  // Outputs are settled half a period after the rising edge
  always @(posedge gwe) begin
    #(CLK_PERIOD / 2);
    if (rst) begin
      if (wb_we !== 1'b0 || dmem_we !== 1'b0) begin
        other_errors++;
        $display("Write enable not low during reset at %0t ns", $time);
      end
    end else begin
      if (wb_we !== 1'b0 && wb_we !== 1'b1) begin
        other_errors++;
        $display("Commit enable unknown at %0t ns", $time);
      end else if (wb_we) begin
        check_commit();
      end
      if (dmem_we === 1'b1) begin
        check_store();
      end
    end
  end

  initial begin
    int rnd;
    int total;
    rnd = $urandom(SEED);
    for (int a = 0; a < 65536; a++) begin
      imem[a] = 16'h0000;
      dmem[a] = 16'($urandom);
    end
    build_program();
    for (int i = 0; i < n_entries; i++) begin
      imem[START_PC + 16'(i)] = tab_insn[i];
    end
    table_ready = 1'b1;

    while (commits_seen < n_wb || stores_seen < n_st) begin
      @(posedge gwe);
    end
    // A few more cycles to catch stray commits
    repeat (8) @(posedge gwe);

    total = mismatches + other_errors + dut_i.u_props.assert_fails;
    $display("Mismatches %0d, other errors %0d, failed assertions %0d, commits %0d, stores %0d",
             mismatches, other_errors, dut_i.u_props.assert_fails, commits_seen, stores_seen);
    if (total == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    int limit_cycles;
    wait (table_ready);
    limit_cycles = n_entries * 4 + 40;
    #(limit_cycles * CLK_PERIOD);
    $display("Timeout after %0d cycles with %0d of %0d commits and %0d of %0d stores seen",
             limit_cycles, commits_seen, n_wb, stores_seen, n_st);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// File: build.f
src/lc4_pkg.sv
src/lc4_decoder.sv
src/lc4_regfile.sv
src/lc4_alu.sv
src/lc4_hazard_unit.sv
src/lc4_branch_unit.sv
src/lc4_processor.sv
test/lc4_clock_gen.sv
test/lc4_properties.sv
test/lc4_tb.sv
